/* design/exec_pkg.sv */
//####################################################################
// Shared definitions for the SIMD execute stage
// Lane and register index widths, ALU operation codes,
// operand-2 and mask source encodings, comparison classification
//####################################################################

package exec_pkg;

	localparam int LANE_WIDTH = 32;
	localparam int REG_IDX_WIDTH = 5;

	// Operation codes decoded upstream
	typedef enum logic [3:0] {
		ADD     = 4'd0,
		SUB     = 4'd1,
		AND     = 4'd2,
		OR      = 4'd3,
		XOR     = 4'd4,
		CMP_EQ  = 4'd5,
		CMP_NE  = 4'd6,
		CMP_LTU = 4'd7,
		CMP_LTS = 4'd8
	} alu_op_t;

	// Where the second operand comes from
	typedef enum logic [1:0] {
		SCALAR2   = 2'd0,
		VECTOR2   = 2'd1,
		IMMEDIATE = 2'd2
	} op2_src_t;

	// Writeback mask origin
	typedef enum logic [1:0] {
		SCALAR1      = 2'd0,
		SCALAR1_INV  = 2'd1,
		MASK_SCALAR2 = 2'd2,
		ALL_ONES     = 2'd3
	} mask_src_t;

	// True for ops whose lane flags get packed into the result
	function automatic logic is_compare(input alu_op_t op);
		return op == CMP_EQ || op == CMP_NE || op == CMP_LTU || op == CMP_LTS;
	endfunction

endpackage

/* design/operand_select.sv */
//####################################################################
// Operand selection for the execute stage
// Forwarding from the stage result register, scalar broadcast,
// operand 1/2 muxing and writeback mask generation
//####################################################################

`timescale 1ns/100ps

module operand_select #(
	parameter int NUM_LANES = 16
) (
	input  logic                                          op1_is_vector_i,
	input  exec_pkg::op2_src_t                            op2_src_i,
	input  exec_pkg::mask_src_t                           mask_src_i,
	input  logic [exec_pkg::LANE_WIDTH-1:0]               immediate_i,
	input  logic [exec_pkg::REG_IDX_WIDTH-1:0]            scalar_sel1_i,
	input  logic [exec_pkg::REG_IDX_WIDTH-1:0]            scalar_sel2_i,
	input  logic [exec_pkg::REG_IDX_WIDTH-1:0]            vector_sel1_i,
	input  logic [exec_pkg::REG_IDX_WIDTH-1:0]            vector_sel2_i,
	input  logic [exec_pkg::LANE_WIDTH-1:0]               scalar_value1_i,
	input  logic [exec_pkg::LANE_WIDTH-1:0]               scalar_value2_i,
	input  logic [NUM_LANES*exec_pkg::LANE_WIDTH-1:0]     vector_value1_i,
	input  logic [NUM_LANES*exec_pkg::LANE_WIDTH-1:0]     vector_value2_i,
	input  logic [exec_pkg::REG_IDX_WIDTH-1:0]            fwd_reg_i,
	input  logic                                          fwd_scalar_en_i,
	input  logic                                          fwd_vector_en_i,
	input  logic [NUM_LANES*exec_pkg::LANE_WIDTH-1:0]     fwd_result_i,
	input  logic [NUM_LANES-1:0]                          fwd_mask_i,
	output logic [NUM_LANES*exec_pkg::LANE_WIDTH-1:0]     operand1_o,
	output logic [NUM_LANES*exec_pkg::LANE_WIDTH-1:0]     operand2_o,
	output logic [NUM_LANES-1:0]                          mask_o
);

	import exec_pkg::*;

	logic [LANE_WIDTH-1:0] scalar1_fwd;
	logic [LANE_WIDTH-1:0] scalar2_fwd;
	logic [NUM_LANES*LANE_WIDTH-1:0] vector1_fwd;
	logic [NUM_LANES*LANE_WIDTH-1:0] vector2_fwd;

	// Scalar read takes lane 0 of the newest result on a match
	function automatic logic [LANE_WIDTH-1:0] fwd_scalar(
		input logic [REG_IDX_WIDTH-1:0] sel,
		input logic [LANE_WIDTH-1:0] reg_data,
		input logic [REG_IDX_WIDTH-1:0] wb_reg,
		input logic wb_en,
		input logic [NUM_LANES*LANE_WIDTH-1:0] wb_result);
		if (wb_en && sel == wb_reg)
			return wb_result[LANE_WIDTH-1:0];
		return reg_data;
	endfunction

	// Vector read replaces only the lanes the last write enabled
	function automatic logic [NUM_LANES*LANE_WIDTH-1:0] fwd_vector(
		input logic [REG_IDX_WIDTH-1:0] sel,
		input logic [NUM_LANES*LANE_WIDTH-1:0] reg_data,
		input logic [REG_IDX_WIDTH-1:0] wb_reg,
		input logic wb_en,
		input logic [NUM_LANES*LANE_WIDTH-1:0] wb_result,
		input logic [NUM_LANES-1:0] wb_mask);
		logic [NUM_LANES*LANE_WIDTH-1:0] merged;
		merged = reg_data;
		if (wb_en && sel == wb_reg)
		begin
			for (int lane = 0; lane < NUM_LANES; lane++)
			begin
				if (wb_mask[lane])
					merged[lane*LANE_WIDTH +: LANE_WIDTH] =
						wb_result[lane*LANE_WIDTH +: LANE_WIDTH];
			end
		end
		return merged;
	endfunction

	assign scalar1_fwd = fwd_scalar(scalar_sel1_i, scalar_value1_i, fwd_reg_i,
		fwd_scalar_en_i, fwd_result_i);
	assign scalar2_fwd = fwd_scalar(scalar_sel2_i, scalar_value2_i, fwd_reg_i,
		fwd_scalar_en_i, fwd_result_i);
	assign vector1_fwd = fwd_vector(vector_sel1_i, vector_value1_i, fwd_reg_i,
		fwd_vector_en_i, fwd_result_i, fwd_mask_i);
	assign vector2_fwd = fwd_vector(vector_sel2_i, vector_value2_i, fwd_reg_i,
		fwd_vector_en_i, fwd_result_i, fwd_mask_i);

	assign operand1_o = op1_is_vector_i ? vector1_fwd : {NUM_LANES{scalar1_fwd}};

	always_comb
	begin
		case (op2_src_i)
			SCALAR2:   operand2_o = {NUM_LANES{scalar2_fwd}};
			VECTOR2:   operand2_o = vector2_fwd;
			IMMEDIATE: operand2_o = {NUM_LANES{immediate_i}};
			default:   operand2_o = '0;
		endcase
	end

	always_comb
	begin
		case (mask_src_i)
			SCALAR1:      mask_o = scalar1_fwd[NUM_LANES-1:0];
			SCALAR1_INV:  mask_o = ~scalar1_fwd[NUM_LANES-1:0];
			MASK_SCALAR2: mask_o = scalar2_fwd[NUM_LANES-1:0];
			default:      mask_o = '1;
		endcase
	end

endmodule

/* design/lane_alu.sv */
//####################################################################
// Single lane integer ALU
// Wrapping add/sub, bitwise logic, equality and ordered compares
//####################################################################

`timescale 1ns/100ps

module lane_alu (
	input  exec_pkg::alu_op_t                op_i,
	input  logic [exec_pkg::LANE_WIDTH-1:0]  a_i,
	input  logic [exec_pkg::LANE_WIDTH-1:0]  b_i,
	output logic [exec_pkg::LANE_WIDTH-1:0]  result_o,
	output logic                             flag_o
);

	import exec_pkg::*;

	logic [LANE_WIDTH-1:0] difference;

	// Shared by subtract and the equality checks
	assign difference = a_i - b_i;

	always_comb
	begin
		case (op_i)
			ADD:     result_o = a_i + b_i;
			SUB:     result_o = difference;
			AND:     result_o = a_i & b_i;
			OR:      result_o = a_i | b_i;
			XOR:     result_o = a_i ^ b_i;
			default: result_o = '0;
		endcase
	end

	always_comb
	begin
		case (op_i)
			CMP_EQ:  flag_o = difference == '0;
			CMP_NE:  flag_o = difference != '0;
			CMP_LTU: flag_o = a_i < b_i;
			// Sign bit matters here only
			CMP_LTS: flag_o = $signed(a_i) < $signed(b_i);
			default: flag_o = 1'b0;
		endcase
	end

endmodule

/* design/result_merge.sv */
//####################################################################
// Result merge and output register of the execute stage
// Packs per-lane compare flags, registers result,
// writeback register, enables and mask
//####################################################################

`timescale 1ns/100ps

module result_merge #(
	parameter int NUM_LANES = 16
) (
	input  logic                                       clk,
	input  logic                                       reset,
	input  exec_pkg::alu_op_t                          op_i,
	input  logic [NUM_LANES*exec_pkg::LANE_WIDTH-1:0]  lane_results_i,
	input  logic [NUM_LANES-1:0]                       lane_flags_i,
	input  logic [NUM_LANES-1:0]                       mask_i,
	input  logic [exec_pkg::REG_IDX_WIDTH-1:0]         writeback_reg_i,
	input  logic                                       enable_scalar_writeback_i,
	input  logic                                       enable_vector_writeback_i,
	output logic [NUM_LANES*exec_pkg::LANE_WIDTH-1:0]  ex_result_o,
	output logic [exec_pkg::REG_IDX_WIDTH-1:0]         ex_writeback_reg_o,
	output logic                                       ex_enable_scalar_writeback_o,
	output logic                                       ex_enable_vector_writeback_o,
	output logic [NUM_LANES-1:0]                       ex_mask_o
);

	import exec_pkg::*;

	logic [NUM_LANES*LANE_WIDTH-1:0] result_nxt;
	logic [NUM_LANES-1:0] mask_nxt;

	// Compare flags land in the low bits, lane k at bit k
	always_comb
	begin
		result_nxt = lane_results_i;
		if (is_compare(op_i))
		begin
			result_nxt = '0;
			result_nxt[NUM_LANES-1:0] = lane_flags_i;
		end
	end

	// A bubble carries no mask
	assign mask_nxt = (enable_scalar_writeback_i || enable_vector_writeback_i)
		? mask_i : '0;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			ex_result_o <= '0;
			ex_writeback_reg_o <= '0;
			ex_enable_scalar_writeback_o <= 1'b0;
			ex_enable_vector_writeback_o <= 1'b0;
			ex_mask_o <= '0;
		end
		else
		begin
			ex_result_o <= result_nxt;
			ex_writeback_reg_o <= writeback_reg_i;
			ex_enable_scalar_writeback_o <= enable_scalar_writeback_i;
			ex_enable_vector_writeback_o <= enable_vector_writeback_i;
			ex_mask_o <= mask_nxt;
		end
	end

endmodule

/* design/execute_stage.sv */
//####################################################################
// SIMD execute stage top level
// Operand selector, one ALU per lane and the result register
//####################################################################

`timescale 1ns/100ps

module execute_stage #(
	parameter int NUM_LANES = 16
) (
	input  logic                                       clk,
	input  logic                                       reset,

	// Decoded instruction
	input  exec_pkg::alu_op_t                          op_i,
	input  logic                                       op1_is_vector_i,
	input  exec_pkg::op2_src_t                         op2_src_i,
	input  exec_pkg::mask_src_t                        mask_src_i,
	input  logic [exec_pkg::LANE_WIDTH-1:0]            immediate_i,
	input  logic [exec_pkg::REG_IDX_WIDTH-1:0]         writeback_reg_i,
	input  logic                                       enable_scalar_writeback_i,
	input  logic                                       enable_vector_writeback_i,
	input  logic [exec_pkg::REG_IDX_WIDTH-1:0]         scalar_sel1_i,
	input  logic [exec_pkg::REG_IDX_WIDTH-1:0]         scalar_sel2_i,
	input  logic [exec_pkg::REG_IDX_WIDTH-1:0]         vector_sel1_i,
	input  logic [exec_pkg::REG_IDX_WIDTH-1:0]         vector_sel2_i,

	// Register file read data
	input  logic [exec_pkg::LANE_WIDTH-1:0]            scalar_value1_i,
	input  logic [exec_pkg::LANE_WIDTH-1:0]            scalar_value2_i,
	input  logic [NUM_LANES*exec_pkg::LANE_WIDTH-1:0]  vector_value1_i,
	input  logic [NUM_LANES*exec_pkg::LANE_WIDTH-1:0]  vector_value2_i,

	output logic [NUM_LANES*exec_pkg::LANE_WIDTH-1:0]  ex_result_o,
	output logic [exec_pkg::REG_IDX_WIDTH-1:0]         ex_writeback_reg_o,
	output logic                                       ex_enable_scalar_writeback_o,
	output logic                                       ex_enable_vector_writeback_o,
	output logic [NUM_LANES-1:0]                       ex_mask_o
);

	import exec_pkg::*;

	logic [NUM_LANES*LANE_WIDTH-1:0] operand1;
	logic [NUM_LANES*LANE_WIDTH-1:0] operand2;
	logic [NUM_LANES*LANE_WIDTH-1:0] lane_result;
	logic [NUM_LANES-1:0] lane_flag;
	logic [NUM_LANES-1:0] mask_val;

	// Forwarding taps the registered outputs
	operand_select #(
		.NUM_LANES(NUM_LANES)
	) operand_select_i (
		.op1_is_vector_i(op1_is_vector_i),
		.op2_src_i(op2_src_i),
		.mask_src_i(mask_src_i),
		.immediate_i(immediate_i),
		.scalar_sel1_i(scalar_sel1_i),
		.scalar_sel2_i(scalar_sel2_i),
		.vector_sel1_i(vector_sel1_i),
		.vector_sel2_i(vector_sel2_i),
		.scalar_value1_i(scalar_value1_i),
		.scalar_value2_i(scalar_value2_i),
		.vector_value1_i(vector_value1_i),
		.vector_value2_i(vector_value2_i),
		.fwd_reg_i(ex_writeback_reg_o),
		.fwd_scalar_en_i(ex_enable_scalar_writeback_o),
		.fwd_vector_en_i(ex_enable_vector_writeback_o),
		.fwd_result_i(ex_result_o),
		.fwd_mask_i(ex_mask_o),
		.operand1_o(operand1),
		.operand2_o(operand2),
		.mask_o(mask_val)
	);

	for (genvar lane = 0; lane < NUM_LANES; lane++)
	begin : gen_lane
		lane_alu lane_alu_i (
			.op_i(op_i),
			.a_i(operand1[lane*LANE_WIDTH +: LANE_WIDTH]),
			.b_i(operand2[lane*LANE_WIDTH +: LANE_WIDTH]),
			.result_o(lane_result[lane*LANE_WIDTH +: LANE_WIDTH]),
			.flag_o(lane_flag[lane])
		);
	end

	result_merge #(
		.NUM_LANES(NUM_LANES)
	) result_merge_i (
		.clk(clk),
		.reset(reset),
		.op_i(op_i),
		.lane_results_i(lane_result),
		.lane_flags_i(lane_flag),
		.mask_i(mask_val),
		.writeback_reg_i(writeback_reg_i),
		.enable_scalar_writeback_i(enable_scalar_writeback_i),
		.enable_vector_writeback_i(enable_vector_writeback_i),
		.ex_result_o(ex_result_o),
		.ex_writeback_reg_o(ex_writeback_reg_o),
		.ex_enable_scalar_writeback_o(ex_enable_scalar_writeback_o),
		.ex_enable_vector_writeback_o(ex_enable_vector_writeback_o),
		.ex_mask_o(ex_mask_o)
	);

endmodule

/* test/execute_stage_assert.sv */
//####################################################################
// Concurrent checks on the execute stage outputs
// Enables under reset, exclusive enables, bubble mask
//####################################################################

`timescale 1ns/100ps

module execute_stage_assert #(
	parameter int NUM_LANES = 16
) (
	input logic                 clk,
	input logic                 reset,
	input logic                 scalar_wb_i,
	input logic                 vector_wb_i,
	input logic [NUM_LANES-1:0] mask_i
);

	// Reset clears both writeback enables
	enables_low_in_reset: assert property (@(posedge clk) reset |-> !scalar_wb_i && !vector_wb_i)
		else $error("Writeback enable high while reset is asserted");

	enables_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(scalar_wb_i && vector_wb_i))
		else $error("Scalar and vector writeback enabled together");

	// A bubble never carries a mask
	bubble_mask_zero: assert property (@(posedge clk) disable iff (reset)
		(!scalar_wb_i && !vector_wb_i) |-> mask_i == '0)
		else $error("Mask nonzero with both writeback enables low");

endmodule

bind execute_stage execute_stage_assert #(.NUM_LANES(NUM_LANES)) assert_i (
	.clk(clk),
	.reset(reset),
	.scalar_wb_i(ex_enable_scalar_writeback_o),
	.vector_wb_i(ex_enable_vector_writeback_o),
	.mask_i(ex_mask_o)
);

/* test/execute_stage_tb.sv */
//####################################################################
// Testbench for the SIMD execute stage
// Clock and reset, data-file stimulus, output checks, timeout
//####################################################################

`timescale 1ns/100ps

module execute_stage_tb;

	import exec_pkg::*;

	localparam int NUM_LANES = 4;
	localparam int VEC_W = NUM_LANES * LANE_WIDTH;

	logic clk;
	logic reset;
	alu_op_t op_i;
	logic op1_is_vector_i;
	op2_src_t op2_src_i;
	mask_src_t mask_src_i;
	logic [LANE_WIDTH-1:0] immediate_i;
	logic [REG_IDX_WIDTH-1:0] writeback_reg_i;
	logic enable_scalar_writeback_i;
	logic enable_vector_writeback_i;
	logic [REG_IDX_WIDTH-1:0] scalar_sel1_i;
	logic [REG_IDX_WIDTH-1:0] scalar_sel2_i;
	logic [REG_IDX_WIDTH-1:0] vector_sel1_i;
	logic [REG_IDX_WIDTH-1:0] vector_sel2_i;
	logic [LANE_WIDTH-1:0] scalar_value1_i;
	logic [LANE_WIDTH-1:0] scalar_value2_i;
	logic [VEC_W-1:0] vector_value1_i;
	logic [VEC_W-1:0] vector_value2_i;
	logic [VEC_W-1:0] ex_result_o;
	logic [REG_IDX_WIDTH-1:0] ex_writeback_reg_o;
	logic ex_enable_scalar_writeback_o;
	logic ex_enable_vector_writeback_o;
	logic [NUM_LANES-1:0] ex_mask_o;

	string data_lines[$];
	int cycle_count = 0;
	int cycle_limit = 0;

	execute_stage #(.NUM_LANES(NUM_LANES)) dut_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_with_failure();
		$display("Test failed");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic compare_field(input string name, input logic [VEC_W-1:0] expected,
		input logic [VEC_W-1:0] actual);
		assert (actual === expected)
		else
		begin
			$display("mismatch at %0t: %s expected %0h, actual %0h",
				$time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_outputs(input logic [VEC_W-1:0] result,
		input logic [REG_IDX_WIDTH-1:0] wb_reg, input logic en_s, input logic en_v,
		input logic [NUM_LANES-1:0] mask);
		compare_field("ex_result_o", result, ex_result_o);
		compare_field("ex_writeback_reg_o", VEC_W'(wb_reg), VEC_W'(ex_writeback_reg_o));
		compare_field("ex_enable_scalar_writeback_o", VEC_W'(en_s),
			VEC_W'(ex_enable_scalar_writeback_o));
		compare_field("ex_enable_vector_writeback_o", VEC_W'(en_v),
			VEC_W'(ex_enable_vector_writeback_o));
		compare_field("ex_mask_o", VEC_W'(mask), VEC_W'(ex_mask_o));
	endtask

	// Run length bound is set once the data file is loaded
	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("Timeout: no end of test after %0d cycles", cycle_count);
			stop_with_failure();
		end
	end

	initial
	begin
		string line_str;
		int fd;
		int field_count;
		logic [3:0] op_field;
		logic [1:0] op2_field;
		logic [1:0] mask_field;
		logic [VEC_W-1:0] exp_result;
		logic [REG_IDX_WIDTH-1:0] exp_reg;
		logic exp_en_s;
		logic exp_en_v;
		logic [NUM_LANES-1:0] exp_mask;
		reset = 1'b1;
		op_i = ADD;
		op1_is_vector_i = 1'b0;
		op2_src_i = SCALAR2;
		mask_src_i = ALL_ONES;
		immediate_i = '0;
		writeback_reg_i = '0;
		enable_scalar_writeback_i = 1'b0;
		enable_vector_writeback_i = 1'b0;
		scalar_sel1_i = '0;
		scalar_sel2_i = '0;
		vector_sel1_i = '0;
		vector_sel2_i = '0;
		scalar_value1_i = '0;
		scalar_value2_i = '0;
		vector_value1_i = '0;
		vector_value2_i = '0;
		fd = $fopen("test/execute_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open test/execute_testdata.txt");
			stop_with_failure();
		end
		// Skip comments and empty lines
		while ($fgets(line_str, fd) > 0)
		begin
			if (line_str.len() > 1 && line_str.getc(0) != "#")
				data_lines.push_back(line_str);
		end
		$fclose(fd);
		cycle_limit = (8 + data_lines.size() + 10) * 2;
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;
		// Nothing issued yet
		check_outputs('0, '0, 1'b0, 1'b0, '0);
		foreach (data_lines[i])
		begin
			field_count = $sscanf(data_lines[i],
				"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				op_field, op1_is_vector_i, op2_field, mask_field, immediate_i,
				writeback_reg_i, enable_scalar_writeback_i, enable_vector_writeback_i,
				scalar_sel1_i, scalar_sel2_i, vector_sel1_i, vector_sel2_i,
				scalar_value1_i, scalar_value2_i, vector_value1_i, vector_value2_i,
				exp_result, exp_reg, exp_en_s, exp_en_v, exp_mask);
			if (field_count != 21)
			begin
				$display("Data line %0d holds %0d fields instead of 21", i, field_count);
				stop_with_failure();
			end
			op_i = alu_op_t'(op_field);
			op2_src_i = op2_src_t'(op2_field);
			mask_src_i = mask_src_t'(mask_field);
			// Registered one edge later
			@(posedge clk);
			#2;
			check_outputs(exp_result, exp_reg, exp_en_s, exp_en_v, exp_mask);
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

/* test/execute_testdata.txt */
# op op1_vec op2_src mask_src imm wb_reg en_s en_v s_sel1 s_sel2 v_sel1 v_sel2 s_val1 s_val2 v_val1 v_val2
# then expected: result wb_reg en_s en_v mask (all hex, vectors lane 3 first)
0 1 1 3 00000000 0a 0 1 01 02 03 04 00000000 00000000 00000040000000300000002000000010 00000004000000030000000200000001 00000044000000330000002200000011 0a 0 1 f
1 1 1 3 00000000 0b 0 1 01 02 03 04 00000000 00000000 00000004000000030000000200000001 00000040000000300000002000000010 FFFFFFC4FFFFFFD3FFFFFFE2FFFFFFF1 0b 0 1 f
2 0 1 3 00000000 0c 0 1 01 02 03 04 0000FF0F 00000000 00000040000000300000002000000010 123456789ABCDEF00F0F0F0FFFFFFFFF 000056080000DE0000000F0F0000FF0F 0c 0 1 f
3 1 0 3 00000000 0d 0 1 01 02 03 04 00000000 00000F00 00000040000000300000002000000010 00000004000000030000000200000001 00000F4000000F3000000F2000000F10 0d 0 1 f
4 1 2 3 FFFF0000 0e 0 1 01 02 03 04 00000000 00000000 00000040000000300000002000000010 00000004000000030000000200000001 FFFF0040FFFF0030FFFF0020FFFF0010 0e 0 1 f
0 0 2 3 00000002 05 1 0 01 02 03 04 FFFFFFFF 00000000 00000040000000300000002000000010 00000004000000030000000200000001 00000001000000010000000100000001 05 1 0 f
0 0 2 3 00000010 06 1 0 05 02 03 04 00000100 00000000 00000040000000300000002000000010 00000004000000030000000200000001 00000011000000110000001100000011 06 1 0 f
0 1 1 0 00000000 07 0 1 01 02 03 04 0000000A 00000000 00000040000000300000002000000010 00000004000000030000000200000001 00000044000000330000002200000011 07 0 1 a
3 1 2 3 00000000 08 0 1 01 02 07 04 00000000 00000000 00000004000000030000000200000001 00000040000000300000002000000010 00000044000000030000002200000001 08 0 1 f
3 1 2 3 00000000 07 0 0 01 02 03 04 00000000 00000000 00000040000000300000002000000010 00000004000000030000000200000001 00000040000000300000002000000010 07 0 0 0
3 1 2 3 00000000 09 0 1 01 02 07 04 00000000 00000000 00000004000000030000000200000001 00000040000000300000002000000010 00000004000000030000000200000001 09 0 1 f
0 1 1 1 00000000 0a 0 1 01 02 03 04 00000003 00000000 00000040000000300000002000000010 00000004000000030000000200000001 00000044000000330000002200000011 0a 0 1 c
1 1 1 2 00000000 0b 0 1 01 02 03 04 00000000 00000006 00000040000000300000002000000010 00000004000000030000000200000001 0000003C0000002D0000001E0000000F 0b 0 1 6
5 1 1 3 00000000 10 1 0 01 02 03 04 00000000 00000000 00000007000000050000000012345678 00000007000000060000000012345679 0000000000000000000000000000000A 10 1 0 f
6 1 1 3 00000000 11 1 0 01 02 03 04 00000000 00000000 00000007000000050000000012345678 00000007000000060000000012345679 00000000000000000000000000000005 11 1 0 f
7 1 1 3 00000000 12 1 0 01 02 03 04 00000000 00000000 80000005000000017FFFFFFFFFFFFFFF 0000000580000000800000007FFFFFFF 00000000000000000000000000000006 12 1 0 f
8 1 1 3 00000000 13 1 0 01 02 03 04 00000000 00000000 80000005000000017FFFFFFFFFFFFFFF 0000000580000000800000007FFFFFFF 00000000000000000000000000000009 13 1 0 f

/* execute_stage.f */
design/exec_pkg.sv
design/operand_select.sv
design/lane_alu.sv
design/result_merge.sv
design/execute_stage.sv
test/execute_stage_assert.sv
test/execute_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module execute_stage_tb \
	-Mdir obj_dir -f execute_stage.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vexecute_stage_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
	echo "FAIL: testbench reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "FAIL: simulation exited with status $status"
	exit 1
fi
echo "PASS"
exit 0
